/* filelist.f */
design/mem_pkg.sv
design/access_decoder.sv
design/cache_level.sv
design/data_memory.sv
design/load_formatter.sv
design/memory_top.sv
tb/memory_properties.sv
tb/memory_tb.sv

/* tb/memory_tb.sv */
`timescale 1ns/1ps

module memory_tb;

    localparam int CLK_PERIOD     = 100;
    localparam int DRIVE_DELAY    = 5;
    localparam int RESET_CYCLES   = 16;
    localparam int RESET_TIMEOUT  = 64;
    localparam int L1_LINES       = 16;
    localparam int L2_LINES       = 64;
    localparam int MEM_ADDR_WIDTH = 12;
    // All tests stay inside the first 256 words
    localparam int WINDOW_WORDS   = 256;
    localparam int RANDOM_OPS     = 300;

    logic             clk;
    logic             reset_i;
    logic             mem_read_i;
    logic             mem_write_i;
    mem_pkg::size_e   size_src_i;
    logic [31:0]      addr_i;
    logic [31:0]      write_data_i;
    logic [31:0]      read_data_o;
    logic             data_valid_o;
    mem_pkg::source_e source_o;

    // Reference state as a sparse memory plus tag/valid shadows of both levels
    logic [31:0] model_mem [int];
    bit          l1_valid [L1_LINES];
    int unsigned l1_tag   [L1_LINES];
    bit          l2_valid [L2_LINES];
    int unsigned l2_tag   [L2_LINES];

    // Expected outputs for the cycle currently applied
    bit               chk_active;
    bit               exp_valid;
    logic [31:0]      exp_data;
    mem_pkg::source_e exp_src;

    int check_count;
    int error_count;
    int test_num;
    int test_start_errors;

    memory_top #(
        .L1_LINES       (L1_LINES),
        .L2_LINES       (L2_LINES),
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) DUT (
        .clk          (clk),
        .reset_i      (reset_i),
        .mem_read_i   (mem_read_i),
        .mem_write_i  (mem_write_i),
        .size_src_i   (size_src_i),
        .addr_i       (addr_i),
        .write_data_i (write_data_i),
        .read_data_o  (read_data_o),
        .data_valid_o (data_valid_o),
        .source_o     (source_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        reset_i = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset_i = 1'b0;
    end

    function automatic int size_bytes(input mem_pkg::size_e size);
        case (size)
            mem_pkg::SIZE_B, mem_pkg::SIZE_BU: return 1;
            mem_pkg::SIZE_H, mem_pkg::SIZE_HU: return 2;
            default:                           return 4;
        endcase
    endfunction

    function automatic bit size_signed(input mem_pkg::size_e size);
        return (size == mem_pkg::SIZE_B) || (size == mem_pkg::SIZE_H);
    endfunction

    function automatic int line_index(input logic [31:0] addr, input int lines);
        return int'((addr >> 2) % lines);
    endfunction

    function automatic int unsigned line_tag(input logic [31:0] addr, input int lines);
        return int'((addr >> 2) / lines);
    endfunction

    // Fill word mixes every address bit
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9E37_79B1) ^ 32'h5A3C_0F96;
    endfunction

    // Expected load value and serving level before the edge updates anything
    function automatic logic [31:0] ref_read(input logic [31:0] addr,
                                             input mem_pkg::size_e size,
                                             output mem_pkg::source_e src);
        logic [31:0] word;
        logic [31:0] value;
        int          n;
        int          off;
        int          i1;
        int          i2;
        word  = model_mem[int'(addr >> 2)];
        n     = size_bytes(size);
        off   = int'(addr[1:0]);
        value = '0;
        for (int k = 0; k < n; k++) begin
            value[8*k +: 8] = word[8*(off+k) +: 8];
        end
        if (size_signed(size) && value[8*n-1]) begin
            value = value | (32'hFFFF_FFFF << (8 * n));
        end
        i1 = line_index(addr, L1_LINES);
        i2 = line_index(addr, L2_LINES);
        if (l1_valid[i1] && l1_tag[i1] == line_tag(addr, L1_LINES)) begin
            src = mem_pkg::SRC_L1;
        end else if (l2_valid[i2] && l2_tag[i2] == line_tag(addr, L2_LINES)) begin
            src = mem_pkg::SRC_L2;
        end else begin
            src = mem_pkg::SRC_MEM;
        end
        return value;
    endfunction

    // After any read the line is resident in both levels
    task automatic allocate_lines(input logic [31:0] addr);
        l1_valid[line_index(addr, L1_LINES)] = 1'b1;
        l1_tag[line_index(addr, L1_LINES)]   = line_tag(addr, L1_LINES);
        l2_valid[line_index(addr, L2_LINES)] = 1'b1;
        l2_tag[line_index(addr, L2_LINES)]   = line_tag(addr, L2_LINES);
    endtask

    // Writes touch memory only and leave the shadow tags alone
    task automatic store_model(input logic [31:0] addr, input mem_pkg::size_e size,
                               input logic [31:0] wdata);
        logic [31:0] word;
        int          key;
        int          n;
        int          off;
        key  = int'(addr >> 2);
        n    = size_bytes(size);
        off  = int'(addr[1:0]);
        word = model_mem.exists(key) ? model_mem[key] : 'x;
        for (int k = 0; k < n; k++) begin
            word[8*(off+k) +: 8] = wdata[8*k +: 8];
        end
        model_mem[key] = word;
    endtask

    task automatic check_data(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s: got 0x%08h expected 0x%08h at %0t",
                     name, actual, expected, $time);
        end
    endtask

    task automatic check_valid(input string name, input logic actual,
                               input logic expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s: got 0x%0h expected 0x%0h at %0t",
                     name, actual, expected, $time);
        end
    endtask

    task automatic check_source(input string name, input mem_pkg::source_e actual,
                                input mem_pkg::source_e expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s: got 0x%0h (%s) expected 0x%0h (%s) at %0t",
                     name, actual, actual.name(), expected, expected.name(), $time);
        end
    endtask

    // Sample one time unit before the next rising edge
    initial begin
        forever begin
            @(posedge clk);
            #(CLK_PERIOD - 1);
            if (chk_active) begin
                check_valid("data_valid_o", data_valid_o, exp_valid);
                if (exp_valid) begin
                    check_data("read_data_o", read_data_o, exp_data);
                end
                check_source("source_o", source_o, exp_src);
            end
        end
    end

    // Called DRIVE_DELAY after an edge, returns DRIVE_DELAY after the next one
    task automatic drive_access(input bit is_write, input mem_pkg::size_e size,
                                input logic [31:0] addr, input logic [31:0] wdata);
        mem_pkg::source_e src;
        logic [31:0]      data;
        mem_read_i   = ~is_write;
        mem_write_i  = is_write;
        size_src_i   = size;
        addr_i       = addr;
        write_data_i = wdata;
        if (is_write) begin
            exp_valid = 1'b0;
            exp_src   = mem_pkg::SRC_NONE;
            store_model(addr, size, wdata);
        end else begin
            data      = ref_read(addr, size, src);
            exp_valid = 1'b1;
            exp_data  = data;
            exp_src   = src;
            allocate_lines(addr);
        end
        chk_active = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic drive_idle();
        mem_read_i  = 1'b0;
        mem_write_i = 1'b0;
        exp_valid   = 1'b0;
        exp_src     = mem_pkg::SRC_NONE;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic begin_test();
        test_start_errors = error_count;
    endtask

    // One idle cycle lets the last access be checked first
    task automatic end_test(input string name);
        int errs;
        drive_idle();
        test_num++;
        errs = error_count - test_start_errors;
        if (errs == 0) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: FAILED with %0d errors", test_num, name, errs);
        end
    endtask

    task automatic wait_reset_release(output bit released);
        int cycles;
        cycles = 0;
        while (reset_i !== 1'b0 && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        released = (reset_i === 1'b0);
        #DRIVE_DELAY;
    endtask

    task automatic preload_window();
        for (int w = 0; w < WINDOW_WORDS; w++) begin
            drive_access(1'b1, mem_pkg::SIZE_W, w * 4, fill_word(w * 4));
        end
        drive_idle();
    endtask

    task automatic test_random();
        mem_pkg::size_e sizes [5];
        mem_pkg::size_e size;
        int             n;
        int             off;
        int             word_idx;
        bit             is_write;
        sizes = '{mem_pkg::SIZE_B, mem_pkg::SIZE_BU, mem_pkg::SIZE_H,
                  mem_pkg::SIZE_HU, mem_pkg::SIZE_W};
        begin_test();
        for (int i = 0; i < RANDOM_OPS; i++) begin
            size     = sizes[$urandom_range(0, 4)];
            n        = size_bytes(size);
            off      = (int'($urandom_range(0, 3)) / n) * n;
            word_idx = $urandom_range(0, WINDOW_WORDS - 1);
            is_write = ($urandom_range(0, 99) < 45);
            drive_access(is_write, size, word_idx * 4 + off, $urandom());
        end
        end_test("random accesses");
    endtask

    initial begin
        bit reset_ok;
        void'($urandom(74625));
        mem_read_i   = 1'b0;
        mem_write_i  = 1'b0;
        size_src_i   = mem_pkg::SIZE_W;
        addr_i       = '0;
        write_data_i = '0;
        chk_active   = 1'b0;
        exp_valid    = 1'b0;
        exp_data     = '0;
        exp_src      = mem_pkg::SRC_NONE;
        check_count  = 0;
        error_count  = 0;
        test_num     = 0;
        // Reset clears every valid bit
        for (int i = 0; i < L1_LINES; i++) begin
            l1_valid[i] = 1'b0;
        end
        for (int i = 0; i < L2_LINES; i++) begin
            l2_valid[i] = 1'b0;
        end

        wait_reset_release(reset_ok);
        if (!reset_ok) begin
            $display("ERROR: reset was not released within %0d cycles", RESET_TIMEOUT);
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            preload_window();

            begin_test();
            drive_access(1'b0, mem_pkg::SIZE_W, 32'h040, '0);
            drive_access(1'b0, mem_pkg::SIZE_W, 32'h040, '0);
            drive_access(1'b0, mem_pkg::SIZE_W, 32'h3FC, '0);
            drive_access(1'b0, mem_pkg::SIZE_W, 32'h3FC, '0);
            end_test("first reads from memory then L1");

            begin_test();
            drive_access(1'b1, mem_pkg::SIZE_W, 32'h080, 32'h1234_5678);
            drive_access(1'b0, mem_pkg::SIZE_W, 32'h080, '0);
            drive_access(1'b0, mem_pkg::SIZE_W, 32'h080, '0);
            drive_access(1'b1, mem_pkg::SIZE_W, 32'h080, 32'hCAFE_F00D);
            drive_access(1'b0, mem_pkg::SIZE_W, 32'h080, '0);
            end_test("word write and L1 update");

            begin_test();
            drive_access(1'b1, mem_pkg::SIZE_B, 32'h0C0, 32'h0000_0081);
            drive_access(1'b1, mem_pkg::SIZE_B, 32'h0C1, 32'h0000_007F);
            drive_access(1'b1, mem_pkg::SIZE_H, 32'h0C2, 32'h0000_BEEF);
            drive_access(1'b0, mem_pkg::SIZE_W, 32'h0C0, '0);
            drive_access(1'b0, mem_pkg::SIZE_B, 32'h0C0, '0);
            drive_access(1'b0, mem_pkg::SIZE_BU, 32'h0C0, '0);
            drive_access(1'b0, mem_pkg::SIZE_B, 32'h0C1, '0);
            drive_access(1'b0, mem_pkg::SIZE_H, 32'h0C2, '0);
            drive_access(1'b0, mem_pkg::SIZE_HU, 32'h0C2, '0);
            drive_access(1'b0, mem_pkg::SIZE_H, 32'h0C0, '0);
            end_test("sub-word merge and extension");

            // 0x100 and 0x140 share an L1 line but not an L2 line
            begin_test();
            drive_access(1'b0, mem_pkg::SIZE_W, 32'h100, '0);
            drive_access(1'b0, mem_pkg::SIZE_W, 32'h100, '0);
            drive_access(1'b0, mem_pkg::SIZE_W, 32'h140, '0);
            drive_access(1'b0, mem_pkg::SIZE_W, 32'h100, '0);
            end_test("L1 eviction served by L2");

            test_random();

            $display("checks: %0d  errors: %0d", check_count, error_count);
            if (error_count == 0) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
            $finish;
        end
    end

endmodule

/* tb/memory_properties.sv */
`timescale 1ns/1ps

module memory_properties (
    input logic                           clk,
    input logic                           reset_i,
    input logic                           mem_read_i,
    input logic                           mem_write_i,
    input mem_pkg::size_e                 size_src_i,
    input logic [mem_pkg::ADDR_WIDTH-1:0] addr_i,
    input logic                           data_valid_o,
    input mem_pkg::source_e               source_o
);

    logic access;
    logic is_half;

    assign access  = mem_read_i | mem_write_i;
    assign is_half = (size_src_i == mem_pkg::SIZE_H) || (size_src_i == mem_pkg::SIZE_HU);

    // Valid only for reads out of reset
    assert property (@(posedge clk) (mem_write_i || reset_i) |-> !data_valid_o)
        else $error("data_valid_o high during a write or reset");

    // No source without valid data, and the other way round
    assert property (@(posedge clk) (source_o == mem_pkg::SRC_NONE) == !data_valid_o)
        else $error("source_o does not agree with data_valid_o");

    // Natural alignment
    assert property (@(posedge clk) disable iff (reset_i)
                     (access && is_half) |-> (addr_i[0] == 1'b0))
        else $error("misaligned halfword access");

    assert property (@(posedge clk) disable iff (reset_i)
                     (access && size_src_i == mem_pkg::SIZE_W) |-> (addr_i[1:0] == 2'b00))
        else $error("misaligned word access");

endmodule

bind memory_top memory_properties u_properties (
    .clk          (clk),
    .reset_i      (reset_i),
    .mem_read_i   (mem_read_i),
    .mem_write_i  (mem_write_i),
    .size_src_i   (size_src_i),
    .addr_i       (addr_i),
    .data_valid_o (data_valid_o),
    .source_o     (source_o)
);

/* design/memory_top.sv */
`timescale 1ns/1ps

module memory_top #(
    parameter int L1_LINES       = 16,
    parameter int L2_LINES       = 64,
    parameter int MEM_ADDR_WIDTH = 12
) (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic                           mem_read_i,
    input  logic                           mem_write_i,
    input  mem_pkg::size_e                 size_src_i,
    input  logic [mem_pkg::ADDR_WIDTH-1:0] addr_i,
    input  logic [mem_pkg::DATA_WIDTH-1:0] write_data_i,
    output logic [mem_pkg::DATA_WIDTH-1:0] read_data_o,
    output logic                           data_valid_o,
    output mem_pkg::source_e               source_o
);

    mem_pkg::mem_req_t              req;
    mem_pkg::level_resp_t           l1_resp;
    mem_pkg::level_resp_t           l2_resp;
    mem_pkg::level_resp_t           mem_resp;
    logic [mem_pkg::DATA_WIDTH-1:0] mem_rdata;

    access_decoder u_decoder (
        .size_i  (size_src_i),
        .addr_i  (addr_i),
        .wdata_i (write_data_i),
        .read_i  (mem_read_i),
        .write_i (mem_write_i),
        .req_o   (req)
    );

    cache_level #(.LINES(L1_LINES)) l1 (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (req),
        .fill_i  (l2_resp),
        .resp_o  (l1_resp)
    );

    cache_level #(.LINES(L2_LINES)) l2 (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (req),
        .fill_i  (mem_resp),
        .resp_o  (l2_resp)
    );

    data_memory #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) u_memory (
        .clk     (clk),
        .req_i   (req),
        .rdata_o (mem_rdata)
    );

    // Memory always has the word
    assign mem_resp = '{hit: 1'b1, data: mem_rdata};

    load_formatter u_formatter (
        .reset_i      (reset_i),
        .req_i        (req),
        .l1_i         (l1_resp),
        .l2_i         (l2_resp),
        .mem_i        (mem_rdata),
        .read_data_o  (read_data_o),
        .data_valid_o (data_valid_o),
        .source_o     (source_o)
    );

endmodule

/* design/load_formatter.sv */
`timescale 1ns/1ps

module load_formatter (
    input  logic                           reset_i,
    input  mem_pkg::mem_req_t              req_i,
    input  mem_pkg::level_resp_t           l1_i,
    input  mem_pkg::level_resp_t           l2_i,
    input  logic [mem_pkg::DATA_WIDTH-1:0] mem_i,
    output logic [mem_pkg::DATA_WIDTH-1:0] read_data_o,
    output logic                           data_valid_o,
    output mem_pkg::source_e               source_o
);

    localparam int DW = mem_pkg::DATA_WIDTH;

    logic [DW-1:0] word;
    logic [DW-1:0] shifted;

    // Reads only, never while in reset
    assign data_valid_o = req_i.read & ~reset_i;

    // First hitting level wins
    always_comb begin
        if (l1_i.hit) begin
            word = l1_i.data;
        end else if (l2_i.hit) begin
            word = l2_i.data;
        end else begin
            word = mem_i;
        end
    end

    always_comb begin
        if (!data_valid_o) begin
            source_o = mem_pkg::SRC_NONE;
        end else if (l1_i.hit) begin
            source_o = mem_pkg::SRC_L1;
        end else if (l2_i.hit) begin
            source_o = mem_pkg::SRC_L2;
        end else begin
            source_o = mem_pkg::SRC_MEM;
        end
    end

    // Bring the addressed lane down to bit 0
    assign shifted = word >> {req_i.addr[mem_pkg::OFFSET_WIDTH-1:0], 3'b000};

    // Sign or zero extend by size code
    always_comb begin
        case (req_i.size)
            mem_pkg::SIZE_B:  read_data_o = {{(DW-8){shifted[7]}}, shifted[7:0]};
            mem_pkg::SIZE_BU: read_data_o = {{(DW-8){1'b0}}, shifted[7:0]};
            mem_pkg::SIZE_H:  read_data_o = {{(DW-16){shifted[15]}}, shifted[15:0]};
            mem_pkg::SIZE_HU: read_data_o = {{(DW-16){1'b0}}, shifted[15:0]};
            mem_pkg::SIZE_W:  read_data_o = word;
            default:          read_data_o = '0;
        endcase
    end

endmodule

/* design/data_memory.sv */
`timescale 1ns/1ps

module data_memory #(
    // Word address bits
    parameter int MEM_ADDR_WIDTH = 12
) (
    input  logic                           clk,
    input  mem_pkg::mem_req_t              req_i,
    output logic [mem_pkg::DATA_WIDTH-1:0] rdata_o
);

    localparam int DEPTH = 2 ** MEM_ADDR_WIDTH;

    logic [mem_pkg::DATA_WIDTH-1:0] mem_q [DEPTH];
    logic [MEM_ADDR_WIDTH-1:0]      word_addr;

    // Upper address bits are dropped, the array wraps
    assign word_addr = req_i.addr[mem_pkg::OFFSET_WIDTH +: MEM_ADDR_WIDTH];

    // Asynchronous read
    assign rdata_o = mem_q[word_addr];

    // Byte-enabled write at the edge
    always_ff @(posedge clk) begin
        if (req_i.write) begin
            for (int b = 0; b < mem_pkg::BYTES; b++) begin
                if (req_i.be[b]) begin
                    mem_q[word_addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

/* design/cache_level.sv */
`timescale 1ns/1ps

module cache_level #(
    // Must be a power of two
    parameter int LINES = 16
) (
    input  logic                 clk,
    input  logic                 reset_i,
    input  mem_pkg::mem_req_t    req_i,
    input  mem_pkg::level_resp_t fill_i,
    output mem_pkg::level_resp_t resp_o
);

    localparam int IDX_W = $clog2(LINES);
    localparam int TAG_W = mem_pkg::ADDR_WIDTH - mem_pkg::OFFSET_WIDTH - IDX_W;

    // Line storage, one word per line
    logic [LINES-1:0]              valid_q;
    logic [TAG_W-1:0]              tag_q  [LINES];
    logic [mem_pkg::DATA_WIDTH-1:0] data_q [LINES];

    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic             hit;
    logic             read_miss;
    logic             write_hit;

    // Index by word address, tag is the rest
    assign idx = req_i.addr[mem_pkg::OFFSET_WIDTH +: IDX_W];
    assign tag = req_i.addr[mem_pkg::ADDR_WIDTH-1 -: TAG_W];

    assign hit       = valid_q[idx] && (tag_q[idx] == tag);
    assign read_miss = req_i.read && !hit;
    assign write_hit = req_i.write && hit;

    // On a miss the lower level's word passes through, so the level
    // above always sees the current word of this address
    always_comb begin
        resp_o.hit  = hit;
        resp_o.data = hit ? data_q[idx] : fill_i.data;
    end

    // Valid bits
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (read_miss) begin
            valid_q[idx] <= 1'b1;
        end
    end

    // Allocate on read miss, merge lanes on write hit
    // Write misses leave the line alone (no-write-allocate)
    always_ff @(posedge clk) begin
        if (read_miss) begin
            tag_q[idx]  <= tag;
            data_q[idx] <= fill_i.data;
        end else if (write_hit) begin
            for (int b = 0; b < mem_pkg::BYTES; b++) begin
                if (req_i.be[b]) begin
                    data_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

/* design/access_decoder.sv */
`timescale 1ns/1ps

module access_decoder (
    input  mem_pkg::size_e                   size_i,
    input  logic [mem_pkg::ADDR_WIDTH-1:0]   addr_i,
    input  logic [mem_pkg::DATA_WIDTH-1:0]   wdata_i,
    input  logic                             read_i,
    input  logic                             write_i,
    output mem_pkg::mem_req_t                req_o
);

    logic [mem_pkg::BYTES-1:0]        size_mask;
    logic [mem_pkg::BYTES-1:0]        lane_en;
    logic [mem_pkg::DATA_WIDTH-1:0]   lane_data;
    logic [mem_pkg::OFFSET_WIDTH-1:0] byte_off;

    assign byte_off = addr_i[mem_pkg::OFFSET_WIDTH-1:0];

    // Lanes touched by the access before alignment
    always_comb begin
        case (size_i)
            mem_pkg::SIZE_B,
            mem_pkg::SIZE_BU: size_mask = 4'b0001;
            mem_pkg::SIZE_H,
            mem_pkg::SIZE_HU: size_mask = 4'b0011;
            mem_pkg::SIZE_W:  size_mask = 4'b1111;
            // Unknown code, nothing gets written
            default:          size_mask = 4'b0000;
        endcase
    end

    // Offset is assumed naturally aligned, so no lane wraps out
    assign lane_en = size_mask << byte_off;

    // Replicate store data so every candidate lane carries it
    always_comb begin
        case (size_i)
            mem_pkg::SIZE_B,
            mem_pkg::SIZE_BU: lane_data = {mem_pkg::BYTES{wdata_i[7:0]}};
            mem_pkg::SIZE_H,
            mem_pkg::SIZE_HU: lane_data = {(mem_pkg::BYTES / 2){wdata_i[15:0]}};
            default:          lane_data = wdata_i;
        endcase
    end

    // Write wins when both strobes are up
    always_comb begin
        req_o.read  = read_i & ~write_i;
        req_o.write = write_i;
        req_o.addr  = addr_i;
        req_o.be    = lane_en;
        req_o.wdata = lane_data;
        req_o.size  = size_i;
    end

endmodule

/* design/mem_pkg.sv */
package mem_pkg;

    // Word geometry, four byte lanes per word
    localparam int DATA_WIDTH   = 32;
    localparam int ADDR_WIDTH   = 32;
    localparam int BYTES        = DATA_WIDTH / 8;
    localparam int OFFSET_WIDTH = $clog2(BYTES);

    // Load/store size codes, RISC-V funct3 style
    typedef enum logic [2:0] {
        SIZE_B  = 3'b000,
        SIZE_H  = 3'b001,
        SIZE_W  = 3'b010,
        SIZE_BU = 3'b100,
        SIZE_HU = 3'b101
    } size_e;

    // Decoded core request as seen by every level of the hierarchy
    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [ADDR_WIDTH-1:0] addr;
        logic [BYTES-1:0]      be;
        logic [DATA_WIDTH-1:0] wdata;
        size_e                 size;
    } mem_req_t;

    // Answer of one level to the level above it
    typedef struct packed {
        logic                  hit;
        logic [DATA_WIDTH-1:0] data;
    } level_resp_t;

    // Which level served a read
    typedef enum logic [1:0] {
        SRC_L1   = 2'd0,
        SRC_L2   = 2'd1,
        SRC_MEM  = 2'd2,
        SRC_NONE = 2'd3
    } source_e;

endpackage
